/* fir.f */
rtl/fir_pkg.sv
rtl/fir_regs.sv
rtl/fir_sample_buffer.sv
rtl/fir_mac.sv
rtl/fir.sv
tests/fir_tb.sv

/* rtl/fir.sv */
`timescale 1ns/10ps

module fir (
    input  logic           axis_clk,
    input  logic           axis_rst_n,

    // Control port
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::data_t wdata,
    input  logic           arvalid,
    output logic           arready,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,

    // Sample stream in
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,

    // Result stream out
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    input  logic           sm_tready
);

    logic              start;
    fir_pkg::data_t    data_len;
    fir_pkg::tap_cnt_t tap_len;
    fir_pkg::tap_idx_t coef_idx;
    fir_pkg::data_t    coef;
    logic              run_done;
    logic              samp_valid;
    logic              samp_ready;
    fir_pkg::tap_idx_t hist_idx;
    fir_pkg::data_t    hist_data;

    fir_regs i_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .start      (start),
        .data_len   (data_len),
        .tap_len    (tap_len),
        .coef_idx   (coef_idx),
        .coef       (coef),
        .run_done   (run_done)
    );

    fir_sample_buffer i_samples (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .data_len   (data_len),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .samp_valid (samp_valid),
        .samp_ready (samp_ready),
        .hist_idx   (hist_idx),
        .hist_data  (hist_data)
    );

    fir_mac i_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .data_len   (data_len),
        .tap_len    (tap_len),
        .samp_valid (samp_valid),
        .samp_ready (samp_ready),
        .coef_idx   (coef_idx),
        .coef       (coef),
        .hist_idx   (hist_idx),
        .hist_data  (hist_data),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready),
        .run_done   (run_done)
    );

endmodule

/* rtl/fir_mac.sv */
`timescale 1ns/10ps

module fir_mac (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              start,
    input  fir_pkg::data_t    data_len,
    input  fir_pkg::tap_cnt_t tap_len,

    input  logic              samp_valid,
    output logic              samp_ready,
    output fir_pkg::tap_idx_t coef_idx,
    input  fir_pkg::data_t    coef,
    output fir_pkg::tap_idx_t hist_idx,
    input  fir_pkg::data_t    hist_data,

    output logic              sm_tvalid,
    output fir_pkg::data_t    sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready,
    output logic              run_done
);

    logic              adv;
    logic              k_active;
    fir_pkg::tap_idx_t k;
    logic              k_last;

    logic              s1_vld;
    logic              s1_first;
    logic              s1_last;
    fir_pkg::data_t    s1_coef;
    fir_pkg::data_t    s1_samp;

    logic              p_vld;
    logic              p_first;
    logic              p_last;
    fir_pkg::data_t    prod;

    fir_pkg::data_t    acc;
    fir_pkg::data_t    sum;
    fir_pkg::data_t    res_cnt;
    logic              res_load;
    logic              sm_fire;

    // Whole pipeline holds while a finished sum waits on a full output
    assign adv = !(p_vld && p_last && sm_tvalid && !sm_tready);

    // Next sample only after the last history read of the current one
    assign samp_ready = adv && !k_active;

    assign k_last   = (fir_pkg::tap_cnt_t'(k) + 1'b1) >= tap_len;
    assign coef_idx = k;
    assign hist_idx = k;

    // ------------------------------------------------------------------
    // Tap sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            k_active <= 1'b0;
            k        <= '0;
        end else if (adv) begin
            if (samp_valid && samp_ready) begin
                k_active <= 1'b1;
                k        <= '0;
            end else if (k_active) begin
                if (k_last) begin
                    k_active <= 1'b0;
                end else begin
                    k <= k + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Fetch, multiply and accumulate stages
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            s1_vld   <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
            p_vld    <= 1'b0;
            p_first  <= 1'b0;
            p_last   <= 1'b0;
        end else if (adv) begin
            s1_vld   <= k_active;
            s1_first <= (k == '0);
            s1_last  <= k_last;
            p_vld    <= s1_vld;
            p_first  <= s1_first;
            p_last   <= s1_last;
        end
    end

    assign sum = (p_first ? '0 : acc) + prod;

    always_ff @(posedge axis_clk) begin
        if (adv) begin
            // Zero taps yield a zero result
            s1_coef <= (tap_len == '0) ? '0 : coef;
            s1_samp <= hist_data;
            prod    <= s1_coef * s1_samp;
            if (p_vld) begin
                acc <= sum;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output register and result count
    // ------------------------------------------------------------------
    assign res_load = adv && p_vld && p_last;
    assign sm_fire  = sm_tvalid && sm_tready;
    assign run_done = sm_fire && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            res_cnt   <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            if (start) begin
                res_cnt <= '0;
            end else if (res_load) begin
                res_cnt <= res_cnt + 1'b1;
            end
            if (res_load) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= (res_cnt + 1'b1) == data_len;
            end else if (sm_fire) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (res_load) begin
            sm_tdata <= sum;
        end
    end

    a_sm_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=>
            $stable(sm_tvalid) && $stable(sm_tdata) && $stable(sm_tlast)
    );

endmodule

/* rtl/fir_pkg.sv */
package fir_pkg;

    // ------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 12;
    localparam int MAX_TAPS = 32;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Index into the coefficient store or the sample history
    typedef logic [$clog2(MAX_TAPS)-1:0] tap_idx_t;

    // Tap count, zero up to MAX_TAPS inclusive
    typedef logic [$clog2(MAX_TAPS+1)-1:0] tap_cnt_t;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    localparam addr_t ADDR_CTRL     = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    localparam addr_t ADDR_TAP_LEN  = 12'h014;

    // Coefficient i at ADDR_TAP_BASE + 4*i
    localparam addr_t ADDR_TAP_BASE = 12'h080;

    // Control register bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DONE_BIT  = 1;
    localparam int CTRL_IDLE_BIT  = 2;

endpackage

/* rtl/fir_regs.sv */
`timescale 1ns/10ps

module fir_regs (
    input  logic              axis_clk,
    input  logic              axis_rst_n,

    input  logic              awvalid,
    output logic              awready,
    input  fir_pkg::addr_t    awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  fir_pkg::data_t    wdata,

    input  logic              arvalid,
    output logic              arready,
    input  fir_pkg::addr_t    araddr,
    output logic              rvalid,
    input  logic              rready,
    output fir_pkg::data_t    rdata,

    output logic              start,
    output fir_pkg::data_t    data_len,
    output fir_pkg::tap_cnt_t tap_len,
    input  fir_pkg::tap_idx_t coef_idx,
    output fir_pkg::data_t    coef,
    input  logic              run_done
);

    fir_pkg::addr_t aw_addr_q;
    logic           aw_held;
    fir_pkg::addr_t ar_addr_q;
    logic           ar_held;

    fir_pkg::data_t coefs [fir_pkg::MAX_TAPS];

    logic idle;
    logic done;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic r_fire;
    logic wr_coef;
    logic start_req;
    logic ctrl_rd;

    // Word-aligned address inside the coefficient window
    function automatic logic is_tap(input fir_pkg::addr_t a);
        return (a >= fir_pkg::ADDR_TAP_BASE) &&
               (a < fir_pkg::ADDR_TAP_BASE + 4 * fir_pkg::MAX_TAPS) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic fir_pkg::tap_idx_t tap_sel(input fir_pkg::addr_t a);
        return fir_pkg::tap_idx_t'((a - fir_pkg::ADDR_TAP_BASE) >> 2);
    endfunction

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Data phase opens once the address is held
    assign wready = aw_held;
    assign rvalid = ar_held;

    // ------------------------------------------------------------------
    // Address channels
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_held <= 1'b0;
            awready <= 1'b0;
            ar_held <= 1'b0;
            arready <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_held <= 1'b1;
            end else if (w_fire) begin
                aw_held <= 1'b0;
            end
            // Writes only while idle, reads at any time for polling
            awready <= idle && !aw_held && !aw_fire;

            if (ar_fire) begin
                ar_held <= 1'b1;
            end else if (r_fire) begin
                ar_held <= 1'b0;
            end
            arready <= !ar_held && !ar_fire;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
        end
        if (ar_fire) begin
            ar_addr_q <= araddr;
        end
    end

    // ------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------
    assign wr_coef   = w_fire && is_tap(aw_addr_q);
    assign start_req = w_fire && (aw_addr_q == fir_pkg::ADDR_CTRL) &&
                       wdata[fir_pkg::CTRL_START_BIT] && idle;
    assign ctrl_rd   = r_fire && (ar_addr_q == fir_pkg::ADDR_CTRL);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_len <= '0;
            tap_len  <= '0;
        end else if (w_fire) begin
            if (aw_addr_q == fir_pkg::ADDR_DATA_LEN) begin
                data_len <= wdata;
            end
            if (aw_addr_q == fir_pkg::ADDR_TAP_LEN) begin
                tap_len <= fir_pkg::tap_cnt_t'(wdata);
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
                coefs[i] <= '0;
            end
        end else if (wr_coef) begin
            coefs[tap_sel(aw_addr_q)] <= wdata;
        end
    end

    // MAC engine fetch port
    assign coef = coefs[coef_idx];

    // ------------------------------------------------------------------
    // Start, done and idle
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start <= 1'b0;
            idle  <= 1'b1;
            done  <= 1'b0;
        end else begin
            start <= start_req;
            if (start_req) begin
                idle <= 1'b0;
            end else if (run_done) begin
                idle <= 1'b1;
            end
            // Set wins over a status read in the same cycle
            if (run_done) begin
                done <= 1'b1;
            end else if (start_req || ctrl_rd) begin
                done <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (ar_addr_q == fir_pkg::ADDR_CTRL) begin
            rdata[fir_pkg::CTRL_DONE_BIT] = done;
            rdata[fir_pkg::CTRL_IDLE_BIT] = idle;
        end else if (ar_addr_q == fir_pkg::ADDR_DATA_LEN) begin
            rdata = data_len;
        end else if (ar_addr_q == fir_pkg::ADDR_TAP_LEN) begin
            rdata = fir_pkg::data_t'(tap_len);
        end else if (is_tap(ar_addr_q)) begin
            rdata = coefs[tap_sel(ar_addr_q)];
        end
    end

    // Configuration is frozen for the whole run
    a_cfg_frozen_busy: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !idle |-> !w_fire && $stable(data_len) && $stable(tap_len)
    );

endmodule

/* rtl/fir_sample_buffer.sv */
`timescale 1ns/10ps

module fir_sample_buffer (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              start,
    input  fir_pkg::data_t    data_len,

    // Run length comes from data_len and not from the input tlast
    input  logic              ss_tvalid,
    input  fir_pkg::data_t    ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,

    output logic              samp_valid,
    input  logic              samp_ready,
    input  fir_pkg::tap_idx_t hist_idx,
    output fir_pkg::data_t    hist_data
);

    fir_pkg::data_t    stage_data;
    logic              stage_full;
    logic              stage_full_nxt;
    fir_pkg::data_t    acc_cnt;
    fir_pkg::data_t    acc_nxt;
    logic              active;
    logic              active_nxt;
    logic              ss_fire;
    logic              samp_fire;

    fir_pkg::tap_idx_t wr_ptr;
    fir_pkg::tap_idx_t wr_next;
    fir_pkg::tap_idx_t rd_ptr;
    fir_pkg::data_t    hist [fir_pkg::MAX_TAPS];

    assign ss_fire    = ss_tvalid && ss_tready;
    assign samp_valid = stage_full;
    assign samp_fire  = stage_full && samp_ready;

    // ------------------------------------------------------------------
    // Stream acceptance and staging
    // ------------------------------------------------------------------
    always_comb begin
        acc_nxt        = acc_cnt;
        active_nxt     = active;
        stage_full_nxt = stage_full;
        if (start) begin
            acc_nxt        = '0;
            active_nxt     = 1'b1;
            stage_full_nxt = 1'b0;
        end else begin
            // Ready is only high with an empty stage
            if (ss_fire) begin
                acc_nxt        = acc_cnt + 1'b1;
                stage_full_nxt = 1'b1;
            end else if (samp_fire) begin
                stage_full_nxt = 1'b0;
            end
        end
        // Acceptance ends once data_len samples are in
        if (acc_nxt == data_len) begin
            active_nxt = 1'b0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            acc_cnt    <= '0;
            active     <= 1'b0;
            stage_full <= 1'b0;
            ss_tready  <= 1'b0;
        end else begin
            acc_cnt    <= acc_nxt;
            active     <= active_nxt;
            stage_full <= stage_full_nxt;
            ss_tready  <= active_nxt && !stage_full_nxt;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ss_fire) begin
            stage_data <= ss_tdata;
        end
    end

    // ------------------------------------------------------------------
    // Circular history with wr_ptr on the newest entry
    // ------------------------------------------------------------------
    assign wr_next = wr_ptr + 1'b1;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (start) begin
            wr_ptr <= '0;
        end else if (samp_fire) begin
            wr_ptr <= wr_next;
        end
    end

    // Zero history at the start of every run
    always_ff @(posedge axis_clk) begin
        if (start) begin
            for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (samp_fire) begin
            hist[wr_next] <= stage_data;
        end
    end

    // Backward index wraps modulo MAX_TAPS
    assign rd_ptr    = wr_ptr - hist_idx;
    assign hist_data = hist[rd_ptr];

    a_no_ready_past_len: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |-> (acc_cnt != data_len)
    );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module fir_tb -f fir.f -o fir_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/fir_sim 2>&1)
echo "$out"
echo "$out" | grep -q -F '*** PASSED ***' && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tests/fir_tb.sv */
`timescale 1ns/10ps

module fir_tb;

    localparam int N_SAMPLES     = 40;
    localparam int TOTAL_SAMPLES = 3 * N_SAMPLES;
    localparam int TIMEOUT_CYC   = TOTAL_SAMPLES * (fir_pkg::MAX_TAPS + 10) + 2000;

    logic           axis_clk;
    logic           axis_rst_n;
    logic           awvalid;
    logic           awready;
    fir_pkg::addr_t awaddr;
    logic           wvalid;
    logic           wready;
    fir_pkg::data_t wdata;
    logic           arvalid;
    logic           arready;
    fir_pkg::addr_t araddr;
    logic           rvalid;
    logic           rready;
    fir_pkg::data_t rdata;
    logic           ss_tvalid;
    fir_pkg::data_t ss_tdata;
    logic           ss_tlast;
    logic           ss_tready;
    logic           sm_tvalid;
    fir_pkg::data_t sm_tdata;
    logic           sm_tlast;
    logic           sm_tready;

    fir_pkg::data_t coefs   [fir_pkg::MAX_TAPS];
    fir_pkg::data_t samples [N_SAMPLES];
    integer         seed;

    fir i_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    always #2 axis_clk = ~axis_clk;

    // ------------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------------
    // Direct-form FIR, zero history before sample 0, 32-bit wrap
    function automatic fir_pkg::data_t fir_ref(input int n, input int taps);
        fir_pkg::data_t acc;
        acc = '0;
        for (int k = 0; k < taps; k++) begin
            if (n - k >= 0) begin
                acc = acc + coefs[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    function automatic fir_pkg::addr_t tap_addr(input int i);
        return fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * i);
    endfunction

    task automatic check_data(input string name, input fir_pkg::data_t exp,
                              input fir_pkg::data_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // Control port and stream tasks
    // ------------------------------------------------------------------
    // Inputs change 1 ns after the rising edge; outputs are stable there
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic reg_write(input fir_pkg::addr_t a, input fir_pkg::data_t d);
        logic hs;
        awvalid = 1'b1;
        awaddr  = a;
        hs = 1'b0;
        while (!hs) begin
            hs = awready;
            next_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = d;
        hs = 1'b0;
        while (!hs) begin
            hs = wready;
            next_cycle();
        end
        wvalid = 1'b0;
    endtask

    task automatic reg_read(input fir_pkg::addr_t a, output fir_pkg::data_t d);
        logic hs;
        arvalid = 1'b1;
        araddr  = a;
        hs = 1'b0;
        while (!hs) begin
            hs = arready;
            next_cycle();
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            hs = rvalid;
            d  = rdata;
            next_cycle();
        end
        rready = 1'b0;
    endtask

    task automatic drive_samples(input int n_samp, input bit bp);
        int   gap;
        logic hs;
        for (int i = 0; i < n_samp; i++) begin
            gap = bp ? ($random(seed) & 3) : 0;
            repeat (gap) next_cycle();
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            ss_tlast  = (i == n_samp - 1);
            hs = 1'b0;
            while (!hs) begin
                hs = ss_tready;
                next_cycle();
            end
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
    endtask

    // Compares every output transfer against the model
    task automatic collect_results(input string name, input int n_samp, input int taps,
                                   input bit bp);
        int   n;
        logic hs;
        n = 0;
        while (n < n_samp) begin
            sm_tready = bp ? (($random(seed) & 3) != 0) : 1'b1;
            hs = sm_tvalid && sm_tready;
            if (hs) begin
                check_data($sformatf("%s result %0d", name, n), fir_ref(n, taps), sm_tdata);
                check_flag($sformatf("%s tlast %0d", name, n), n == n_samp - 1, sm_tlast);
                n++;
            end
            next_cycle();
        end
        sm_tready = 1'b0;
        check_flag({name, " no extra result"}, 1'b0, sm_tvalid);
    endtask

    task automatic run_filter(input string name, input int taps, input bit bp);
        fir_pkg::data_t status;
        reg_write(fir_pkg::ADDR_DATA_LEN, N_SAMPLES);
        reg_write(fir_pkg::ADDR_TAP_LEN, taps);
        reg_write(fir_pkg::ADDR_CTRL, fir_pkg::data_t'(1) << fir_pkg::CTRL_START_BIT);
        // Busy, done cleared by the start
        reg_read(fir_pkg::ADDR_CTRL, status);
        check_data({name, " status while busy"}, 32'h0, status);
        fork
            drive_samples(N_SAMPLES, bp);
            collect_results(name, N_SAMPLES, taps, bp);
        join
        reg_read(fir_pkg::ADDR_CTRL, status);
        check_flag({name, " done"}, 1'b1, status[fir_pkg::CTRL_DONE_BIT]);
        check_flag({name, " idle"}, 1'b1, status[fir_pkg::CTRL_IDLE_BIT]);
        check_data({name, " status after run"}, 32'h6, status);
        // The status read clears done
        reg_read(fir_pkg::ADDR_CTRL, status);
        check_data({name, " status after read"}, 32'h4, status);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        fir_pkg::data_t rd;
        seed       = 58;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (16) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        next_cycle();

        reg_read(fir_pkg::ADDR_CTRL, rd);
        check_data("reset ctrl", 32'h4, rd);
        reg_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_data("reset data_len", 32'h0, rd);
        reg_read(fir_pkg::ADDR_TAP_LEN, rd);
        check_data("reset tap_len", 32'h0, rd);

        // Register read-back
        for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
            coefs[i] = $random(seed);
        end
        reg_write(fir_pkg::ADDR_DATA_LEN, N_SAMPLES);
        reg_write(fir_pkg::ADDR_TAP_LEN, 11);
        for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
            reg_write(tap_addr(i), coefs[i]);
        end
        reg_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_data("readback data_len", N_SAMPLES, rd);
        reg_read(fir_pkg::ADDR_TAP_LEN, rd);
        check_data("readback tap_len", 11, rd);
        for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
            reg_read(tap_addr(i), rd);
            check_data($sformatf("readback coef %0d", i), coefs[i], rd);
        end

        for (int i = 0; i < N_SAMPLES; i++) begin
            samples[i] = $random(seed);
        end
        run_filter("filter 11 taps", 11, 1'b0);
        run_filter("backpressure 11 taps", 11, 1'b1);

        // Fresh samples, full tap count
        for (int i = 0; i < N_SAMPLES; i++) begin
            samples[i] = $random(seed);
        end
        run_filter("restart 32 taps", fir_pkg::MAX_TAPS, 1'b0);

        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge axis_clk);
        $display("Timeout: the test did not complete within %0d clock cycles", TIMEOUT_CYC);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped by the watchdog");
    end

endmodule
